// File: axi_sram.f
+incdir+source
source/axi_pkg.sv
source/mem_pkg.sv
source/mem_port_if.sv
source/axi_rd_ctrl.sv
source/axi_wr_ctrl.sv
source/sram_array.sv
source/axi_sram_top.sv
dv/axi_sram_assert.sv
dv/axi_sram_checker.sv
dv/axi_sram_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run into sim.log, fail on the fail message or a broken run
verilator --binary --timing --assert --timescale 1ns/100ps -f axi_sram.f \
  --top-module axi_sram_tb -o axi_sram_sim > build.log 2>&1 &&
  ./obj_dir/axi_sram_sim > sim.log 2>&1 ||
  { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "ERRORS FOUND" sim.log &&
  { echo "Simulation reported failures, see sim.log"; exit 1; } ||
  { echo "Simulation passed"; exit 0; }

// File: dv/axi_sram_tb.sv
// Testbench for the AXI SRAM, drives directed and random bursts and prints the closing result
`timescale 1ns/100ps
`include "axi_sram_config.svh"

module axi_sram_tb
  import axi_pkg::*, mem_pkg::*;
();

  localparam int NUM_SINGLE  = 16;
  localparam int NUM_INCR    = 12;
  localparam int NUM_CONC    = 8;
  // Writes and reads counted apart, plus FIXED, end crossing and WRAP
  localparam int NUM_BURSTS  = 2*NUM_SINGLE + 2*NUM_INCR + 2*NUM_CONC + 8;
  localparam int MAX_BEATS   = 256;
  localparam int CYCLE_LIMIT = NUM_BURSTS * MAX_BEATS * 4;

  logic       i_aclk = 1'b0;
  logic       i_rst;
  id_t        i_awid;
  byte_addr_t i_awaddr;
  len_t       i_awlen;
  logic [1:0] i_awburst;
  logic       i_awvalid;
  logic       o_awready;
  word_t      i_wdata;
  strb_t      i_wstrb;
  logic       i_wlast;
  logic       i_wvalid;
  logic       o_wready;
  id_t        o_bid;
  logic [1:0] o_bresp;
  logic       o_bvalid;
  logic       i_bready;
  id_t        i_arid;
  byte_addr_t i_araddr;
  len_t       i_arlen;
  logic [1:0] i_arburst;
  logic       i_arvalid;
  logic       o_arready;
  id_t        o_rid;
  word_t      o_rdata;
  logic [1:0] o_rresp;
  logic       o_rlast;
  logic       o_rvalid;
  logic       i_rready;

  int tb_errors = 0;
  int cycles    = 0;

  axi_sram_top u_axi_sram_top (.*);

  axi_sram_checker u_checker (
    .*,
    .i_awready (o_awready),
    .i_wready  (o_wready),
    .i_bid     (o_bid),
    .i_bresp   (o_bresp),
    .i_bvalid  (o_bvalid),
    .i_arready (o_arready),
    .i_rid     (o_rid),
    .i_rdata   (o_rdata),
    .i_rresp   (o_rresp),
    .i_rlast   (o_rlast),
    .i_rvalid  (o_rvalid)
  );

  always #50 i_aclk = ~i_aclk;

  function automatic void show_counts();
    $display("Closing: checker errors %0d, testbench errors %0d", u_checker.errors, tb_errors);
  endfunction

  // Watchdog
  always @(posedge i_aclk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
      show_counts();
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // --------------------
  // Bus tasks
  // --------------------
  task automatic write_burst(input int word, input len_t len, input logic [1:0] burst);
    logic done;
    @(negedge i_aclk);
    i_awid    = id_t'($urandom);
    i_awaddr  = byte_addr_t'(word * WORD_BYTES);
    i_awlen   = len;
    i_awburst = burst;
    i_awvalid = 1'b1;
    do @(posedge i_aclk); while (!o_awready);
    @(negedge i_aclk);
    i_awvalid = 1'b0;
    for (int b = 0; b <= int'(len); b++) begin
      i_wdata  = {$urandom, $urandom};
      i_wstrb  = strb_t'($urandom);
      i_wlast  = (b == int'(len));
      i_wvalid = 1'b1;
      do @(posedge i_aclk); while (!o_wready);
      @(negedge i_aclk);
    end
    i_wvalid = 1'b0;
    i_wlast  = 1'b0;
    // BREADY idles about 30 percent of cycles
    done = 1'b0;
    while (!done) begin
      i_bready = (($urandom % 10) >= 3);
      @(posedge i_aclk);
      done = i_bready && o_bvalid;
      @(negedge i_aclk);
    end
    i_bready = 1'b0;
  endtask

  task automatic read_burst(input int word, input len_t len, input logic [1:0] burst);
    int   beats;
    logic done;
    @(negedge i_aclk);
    i_arid    = id_t'($urandom);
    i_araddr  = byte_addr_t'(word * WORD_BYTES);
    i_arlen   = len;
    i_arburst = burst;
    i_arvalid = 1'b1;
    do @(posedge i_aclk); while (!o_arready);
    @(negedge i_aclk);
    i_arvalid = 1'b0;
    beats = 0;
    done  = 1'b0;
    while (!done) begin
      i_rready = (($urandom % 10) >= 3);
      @(posedge i_aclk);
      if (i_rready && o_rvalid) begin
        beats++;
        done = o_rlast;
      end
      @(negedge i_aclk);
    end
    i_rready = 1'b0;
    if (beats != int'(len) + 1) begin
      tb_errors++;
      $display("** Error @ %0t: read burst gave %0d beats, expected %0d",
               $time, beats, int'(len) + 1);
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    int          words [NUM_SINGLE];
    int          word;
    int          wword;
    int          rword;
    len_t        len;
    len_t        wlen;
    len_t        rlen;
    void'($urandom(48));
    i_rst     = 1'b1;
    i_awid    = '0;
    i_awaddr  = '0;
    i_awlen   = '0;
    i_awburst = BURST_INCR;
    i_awvalid = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_wlast   = 1'b0;
    i_wvalid  = 1'b0;
    i_bready  = 1'b0;
    i_arid    = '0;
    i_araddr  = '0;
    i_arlen   = '0;
    i_arburst = BURST_INCR;
    i_arvalid = 1'b0;
    i_rready  = 1'b0;
    repeat (2) @(posedge i_aclk);
    @(negedge i_aclk);
    i_rst = 1'b0;
    if (!o_awready || !o_arready) begin
      tb_errors++;
      $display("** Error @ %0t: AWREADY or ARREADY is not high after reset", $time);
    end

    // Single beats with random strobes
    for (int n = 0; n < NUM_SINGLE; n++) begin
      words[n] = $urandom_range(`SRAM_DEPTH - 1, 0);
      write_burst(words[n], 8'd0, BURST_INCR);
    end
    for (int n = 0; n < NUM_SINGLE; n++) begin
      read_burst(words[n], 8'd0, BURST_INCR);
    end

    for (int n = 0; n < NUM_INCR; n++) begin
      len  = len_t'($urandom_range(MAX_BEATS - 1, 0));
      word = $urandom_range(`SRAM_DEPTH - MAX_BEATS, 0);
      write_burst(word, len, BURST_INCR);
      read_burst(word, len, BURST_INCR);
    end

    word = $urandom_range(`SRAM_DEPTH - 1, 0);
    write_burst(word, 8'd7, BURST_FIXED);
    read_burst(word, 8'd3, BURST_FIXED);

    // Bursts running off the end of the array
    write_burst(`SRAM_DEPTH - 3, 8'd7, BURST_INCR);
    read_burst(`SRAM_DEPTH - 4, 8'd7, BURST_INCR);
    // Words the dropped beats would alias onto
    read_burst(0, 8'd4, BURST_INCR);

    word = $urandom_range(`SRAM_DEPTH - 4, 0);
    write_burst(word, 8'd3, BURST_WRAP);
    read_burst(word, 8'd3, BURST_WRAP);
    read_burst(word, 8'd3, BURST_INCR);

    // Writes in the lower half, reads in the upper half
    for (int n = 0; n < NUM_CONC; n++) begin
      wword = $urandom_range(`SRAM_DEPTH/2 - 64, 0);
      rword = $urandom_range(`SRAM_DEPTH - 64, `SRAM_DEPTH/2);
      wlen  = len_t'($urandom_range(63, 0));
      rlen  = len_t'($urandom_range(63, 0));
      fork
        write_burst(wword, wlen, BURST_INCR);
        read_burst(rword, rlen, BURST_INCR);
      join
    end

    repeat (4) @(posedge i_aclk);
    tb_errors = tb_errors + u_axi_sram_top.u_axi_sram_assert.fail_count;
    show_counts();
    if (tb_errors == 0 && u_checker.errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: dv/axi_sram_checker.sv
// Scoreboard for the AXI SRAM, keeps a shadow memory from AW and W and checks every R and B
`timescale 1ns/100ps
`include "axi_sram_config.svh"

module axi_sram_checker
  import axi_pkg::*, mem_pkg::*;
(
  input logic       i_aclk,
  input logic       i_rst,
  input id_t        i_awid,
  input byte_addr_t i_awaddr,
  input logic [1:0] i_awburst,
  input logic       i_awvalid,
  input logic       i_awready,
  input word_t      i_wdata,
  input strb_t      i_wstrb,
  input logic       i_wvalid,
  input logic       i_wready,
  input id_t        i_bid,
  input logic [1:0] i_bresp,
  input logic       i_bvalid,
  input logic       i_bready,
  input id_t        i_arid,
  input byte_addr_t i_araddr,
  input len_t       i_arlen,
  input logic [1:0] i_arburst,
  input logic       i_arvalid,
  input logic       i_arready,
  input id_t        i_rid,
  input word_t      i_rdata,
  input logic [1:0] i_rresp,
  input logic       i_rlast,
  input logic       i_rvalid,
  input logic       i_rready
);

  word_t      shadow [`SRAM_DEPTH] = '{default: '0};
  byte_addr_t wr_addr;
  byte_addr_t rd_addr;
  logic [1:0] wr_burst;
  logic [1:0] rd_burst;
  id_t        wr_id;
  id_t        rd_id;
  len_t       rd_len;
  len_t       rd_beat;
  logic       wr_err;
  int         errors = 0;

  // FIXED or INCR beat whose word lies inside the array
  function automatic logic beat_ok(input byte_addr_t addr, input logic [1:0] burst);
    return (burst == BURST_FIXED || burst == BURST_INCR) && (addr / WORD_BYTES < `SRAM_DEPTH);
  endfunction

  // Reference for one read beat, response on top of the data
  function automatic logic [`AXI_DATA_WIDTH+1:0] ref_read(input byte_addr_t addr,
                                                          input logic [1:0] burst);
    if (beat_ok(addr, burst)) begin
      return {RESP_OKAY, shadow[widx_t'(addr / WORD_BYTES)]};
    end
    return {RESP_SLVERR, word_t'(0)};
  endfunction

  function automatic logic [1:0] ref_bresp(input logic any_bad_beat);
    return any_bad_beat ? RESP_SLVERR : RESP_OKAY;
  endfunction

  function automatic void log_error(input string msg);
    errors++;
    $display("** Error @ %0t: %s", $time, msg);
  endfunction

  // --------------------
  // Compare and track
  // --------------------
  always @(posedge i_aclk) begin
    logic [`AXI_DATA_WIDTH+1:0] exp;
    widx_t                      idx;
    if (!i_rst) begin
      if (i_rvalid && i_rready) begin
        exp = ref_read(rd_addr, rd_burst);
        if (i_rdata !== exp[`AXI_DATA_WIDTH-1:0] || i_rresp !== exp[`AXI_DATA_WIDTH +: 2]) begin
          log_error($sformatf("R beat %0d at %h gave %h resp %0d, expected %h resp %0d",
                              rd_beat, rd_addr, i_rdata, i_rresp,
                              exp[`AXI_DATA_WIDTH-1:0], exp[`AXI_DATA_WIDTH +: 2]));
        end
        if (i_rid !== rd_id) begin
          log_error($sformatf("RID %0d, expected %0d", i_rid, rd_id));
        end
        if (i_rlast !== (rd_beat == rd_len)) begin
          log_error($sformatf("RLAST %b on beat %0d of ARLEN %0d", i_rlast, rd_beat, rd_len));
        end
        if (rd_burst == BURST_INCR) begin
          rd_addr = rd_addr + byte_addr_t'(WORD_BYTES);
        end
        rd_beat = rd_beat + 8'd1;
      end
      if (i_bvalid && i_bready) begin
        if (i_bid !== wr_id || i_bresp !== ref_bresp(wr_err)) begin
          log_error($sformatf("B id %0d resp %0d, expected id %0d resp %0d",
                              i_bid, i_bresp, wr_id, ref_bresp(wr_err)));
        end
      end
      if (i_arvalid && i_arready) begin
        rd_id    = i_arid;
        rd_addr  = i_araddr;
        rd_len   = i_arlen;
        rd_burst = i_arburst;
        rd_beat  = '0;
      end
      if (i_awvalid && i_awready) begin
        wr_id    = i_awid;
        wr_addr  = i_awaddr;
        wr_burst = i_awburst;
        wr_err   = 1'b0;
      end
      // Shadow write after the read check, old data on a shared edge
      if (i_wvalid && i_wready) begin
        if (beat_ok(wr_addr, wr_burst)) begin
          idx = widx_t'(wr_addr / WORD_BYTES);
          for (int b = 0; b < WORD_BYTES; b++) begin
            if (i_wstrb[b]) begin
              shadow[idx][b*8 +: 8] = i_wdata[b*8 +: 8];
            end
          end
        end else begin
          wr_err = 1'b1;
        end
        if (wr_burst == BURST_INCR) begin
          wr_addr = wr_addr + byte_addr_t'(WORD_BYTES);
        end
      end
    end
  end

endmodule

// File: dv/axi_sram_assert.sv
// Handshake assertions for the AXI SRAM top level, attached to every axi_sram_top by bind
`timescale 1ns/100ps

module axi_sram_assert
  import axi_pkg::*, mem_pkg::*;
(
  input logic       i_aclk,
  input logic       i_rst,
  input logic       i_awvalid,
  input logic       i_awready,
  input byte_addr_t i_awaddr,
  input len_t       i_awlen,
  input logic       i_wvalid,
  input logic       i_wready,
  input word_t      i_wdata,
  input strb_t      i_wstrb,
  input logic       i_arvalid,
  input logic       i_arready,
  input byte_addr_t i_araddr,
  input logic       i_rvalid,
  input logic       i_rready,
  input word_t      i_rdata,
  input logic       i_rlast,
  input logic       i_bvalid,
  input logic       i_bready,
  input logic [1:0] i_bresp
);

  int fail_count = 0;

  // --------------------
  // Stall stability
  // --------------------
  aw_stable: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr) && $stable(i_awlen))
    else begin
      $error("AW valid or payload changed while stalled");
      fail_count++;
    end

  w_stable: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata) && $stable(i_wstrb))
    else begin
      $error("W valid or payload changed while stalled");
      fail_count++;
    end

  ar_stable: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
    else begin
      $error("AR valid or payload changed while stalled");
      fail_count++;
    end

  r_stable: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rlast))
    else begin
      $error("R valid or payload changed while stalled");
      fail_count++;
    end

  b_stable: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
    else begin
      $error("B valid or response changed while stalled");
      fail_count++;
    end

  rlast_with_rvalid: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_rlast |-> i_rvalid)
    else begin
      $error("RLAST high without RVALID");
      fail_count++;
    end

  // Channels quiet right after reset
  reset_quiet: assert property (@(posedge i_aclk)
    i_rst |=> !i_wready && !i_rvalid && !i_bvalid)
    else begin
      $error("WREADY, RVALID or BVALID high after reset");
      fail_count++;
    end

endmodule

bind axi_sram_top axi_sram_assert u_axi_sram_assert (
  .i_aclk    (i_aclk),
  .i_rst     (i_rst),
  .i_awvalid (i_awvalid),
  .i_awready (o_awready),
  .i_awaddr  (i_awaddr),
  .i_awlen   (i_awlen),
  .i_wvalid  (i_wvalid),
  .i_wready  (o_wready),
  .i_wdata   (i_wdata),
  .i_wstrb   (i_wstrb),
  .i_arvalid (i_arvalid),
  .i_arready (o_arready),
  .i_araddr  (i_araddr),
  .i_rvalid  (o_rvalid),
  .i_rready  (i_rready),
  .i_rdata   (o_rdata),
  .i_rlast   (o_rlast),
  .i_bvalid  (o_bvalid),
  .i_bready  (i_bready),
  .i_bresp   (o_bresp)
);

// File: source/axi_sram_top.sv
// AXI4 slave SRAM top level, plain AXI4 ports wired to the read and write controllers and the array
`timescale 1ns/100ps

module axi_sram_top
  import axi_pkg::*, mem_pkg::*;
(
  input  logic       i_aclk,
  input  logic       i_rst,

  // Write address
  input  id_t        i_awid,
  input  byte_addr_t i_awaddr,
  input  len_t       i_awlen,
  input  logic [1:0] i_awburst,
  input  logic       i_awvalid,
  output logic       o_awready,

  // Write data
  input  word_t      i_wdata,
  input  strb_t      i_wstrb,
  input  logic       i_wlast,
  input  logic       i_wvalid,
  output logic       o_wready,

  // Write response
  output id_t        o_bid,
  output logic [1:0] o_bresp,
  output logic       o_bvalid,
  input  logic       i_bready,

  // Read address
  input  id_t        i_arid,
  input  byte_addr_t i_araddr,
  input  len_t       i_arlen,
  input  logic [1:0] i_arburst,
  input  logic       i_arvalid,
  output logic       o_arready,

  // Read data
  output id_t        o_rid,
  output word_t      o_rdata,
  output logic [1:0] o_rresp,
  output logic       o_rlast,
  output logic       o_rvalid,
  input  logic       i_rready
);

  mem_port_if rd_port ();
  mem_port_if wr_port ();

  axi_rd_ctrl u_rd_ctrl (
    .i_aclk    (i_aclk),
    .i_rst     (i_rst),
    .i_arid    (i_arid),
    .i_araddr  (i_araddr),
    .i_arlen   (i_arlen),
    .i_arburst (i_arburst),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .o_rid     (o_rid),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .o_rlast   (o_rlast),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .mem       (rd_port.ctrl)
  );

  axi_wr_ctrl u_wr_ctrl (
    .i_aclk    (i_aclk),
    .i_rst     (i_rst),
    .i_awid    (i_awid),
    .i_awaddr  (i_awaddr),
    .i_awlen   (i_awlen),
    .i_awburst (i_awburst),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .i_wlast   (i_wlast),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .o_bid     (o_bid),
    .o_bresp   (o_bresp),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .mem       (wr_port.ctrl)
  );

  sram_array u_sram_array (
    .i_aclk (i_aclk),
    .rd     (rd_port.mem),
    .wr     (wr_port.mem)
  );

endmodule

// File: source/sram_array.sv
// Word-wide SRAM with a registered read port and a byte-strobed write port
`timescale 1ns/100ps
`include "axi_sram_config.svh"

module sram_array
  import mem_pkg::*;
(
  input logic     i_aclk,
  mem_port_if.mem rd,
  mem_port_if.mem wr
);

  // Zero contents at simulation start
  word_t mem_q [`SRAM_DEPTH] = '{default: '0};
  word_t rdata_q;

  // Byte merge under the strobes
  always_ff @(posedge i_aclk) begin
    if (wr.en && wr.we) begin
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (wr.wstrb[b]) begin
          mem_q[wr.idx][b*8 +: 8] <= wr.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Old data on a same-edge read and write, held between enables
  always_ff @(posedge i_aclk) begin
    if (rd.en && !rd.we) begin
      rdata_q <= mem_q[rd.idx];
    end
  end

  assign rd.rdata = rdata_q;
  // No read path on the write port
  assign wr.rdata = '0;

endmodule

// File: source/axi_wr_ctrl.sv
// AXI4 write channel controller, takes AW and W beats into the SRAM and returns one B per burst
`timescale 1ns/100ps

module axi_wr_ctrl
  import axi_pkg::*, mem_pkg::*;
(
  input  logic       i_aclk,
  input  logic       i_rst,
  input  id_t        i_awid,
  input  byte_addr_t i_awaddr,
  input  len_t       i_awlen,
  input  logic [1:0] i_awburst,
  input  logic       i_awvalid,
  output logic       o_awready,
  input  word_t      i_wdata,
  input  strb_t      i_wstrb,
  input  logic       i_wlast,
  input  logic       i_wvalid,
  output logic       o_wready,
  output id_t        o_bid,
  output logic [1:0] o_bresp,
  output logic       o_bvalid,
  input  logic       i_bready,
  mem_port_if.ctrl   mem
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  wr_state_e  state_q;
  id_t        id_q;
  len_t       len_q;
  len_t       beat_q;
  burst_e     burst_q;
  byte_addr_t addr_q;
  logic       err_q;
  logic       aw_fire;
  logic       w_fire;
  logic       b_fire;
  logic       beat_ok;
  logic       len_ok;

  assign aw_fire = i_awvalid && o_awready;
  assign w_fire  = i_wvalid && o_wready;
  assign b_fire  = o_bvalid && i_bready;
  assign beat_ok = burst_supported(burst_q) && in_range(addr_q);
  // WLAST must land on beat AWLEN
  assign len_ok  = (i_wlast == (beat_q == len_q));

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      state_q <= WR_IDLE;
    end else begin
      case (state_q)
        WR_IDLE: if (aw_fire) state_q <= WR_DATA;
        WR_DATA: if (w_fire && i_wlast) state_q <= WR_RESP;
        WR_RESP: if (b_fire) state_q <= WR_IDLE;
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  // Sticky error collects every bad beat of the burst
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      id_q    <= i_awid;
      len_q   <= i_awlen;
      burst_q <= burst_e'(i_awburst);
      addr_q  <= i_awaddr;
      beat_q  <= '0;
      err_q   <= 1'b0;
    end else if (w_fire) begin
      if (burst_q == BURST_INCR) begin
        addr_q <= addr_q + byte_addr_t'(WORD_BYTES);
      end
      beat_q <= beat_q + 1'b1;
      err_q  <= err_q || !beat_ok || !len_ok;
    end
  end

  // --------------------
  // Memory port
  // --------------------
  assign mem.en    = w_fire && beat_ok;
  assign mem.we    = 1'b1;
  assign mem.idx   = word_index(addr_q);
  assign mem.wdata = i_wdata;
  assign mem.wstrb = i_wstrb;

  assign o_awready = (state_q == WR_IDLE);
  assign o_wready  = (state_q == WR_DATA);
  assign o_bvalid  = (state_q == WR_RESP);
  assign o_bid     = id_q;
  assign o_bresp   = err_q ? RESP_SLVERR : RESP_OKAY;

endmodule

// File: source/axi_rd_ctrl.sv
// AXI4 read channel controller, accepts AR and streams FIXED or INCR bursts from the SRAM
`timescale 1ns/100ps

module axi_rd_ctrl
  import axi_pkg::*, mem_pkg::*;
(
  input  logic       i_aclk,
  input  logic       i_rst,
  input  id_t        i_arid,
  input  byte_addr_t i_araddr,
  input  len_t       i_arlen,
  input  logic [1:0] i_arburst,
  input  logic       i_arvalid,
  output logic       o_arready,
  output id_t        o_rid,
  output word_t      o_rdata,
  output logic [1:0] o_rresp,
  output logic       o_rlast,
  output logic       o_rvalid,
  input  logic       i_rready,
  mem_port_if.ctrl   mem
);

  typedef enum logic {
    RD_IDLE,
    RD_BURST
  } rd_state_e;

  rd_state_e  state_q;
  id_t        id_q;
  len_t       len_q;
  len_t       beat_q;
  burst_e     burst_q;
  byte_addr_t addr_q;
  byte_addr_t next_addr;
  logic       ar_fire;
  logic       r_fire;
  logic       last_beat;
  logic       beat_err;

  assign ar_fire   = i_arvalid && o_arready;
  assign r_fire    = o_rvalid && i_rready;
  assign last_beat = (beat_q == len_q);
  assign beat_err  = !burst_supported(burst_q) || !in_range(addr_q);

  // FIXED and WRAP keep the address, INCR steps one word
  assign next_addr = (burst_q == BURST_INCR) ? addr_q + byte_addr_t'(WORD_BYTES) : addr_q;

  // --------------------
  // State
  // --------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      state_q <= RD_IDLE;
    end else begin
      case (state_q)
        RD_IDLE:  if (ar_fire) state_q <= RD_BURST;
        RD_BURST: if (r_fire && last_beat) state_q <= RD_IDLE;
        default:  state_q <= RD_IDLE;
      endcase
    end
  end

  // Burst context, address moves on every R transfer
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      id_q    <= i_arid;
      len_q   <= i_arlen;
      burst_q <= burst_e'(i_arburst);
      addr_q  <= i_araddr;
      beat_q  <= '0;
    end else if (r_fire) begin
      addr_q <= next_addr;
      beat_q <= beat_q + 1'b1;
    end
  end

  // --------------------
  // Memory port
  // --------------------
  // Beat 0 fetched on AR, each later beat on the previous R transfer
  assign mem.en    = ar_fire || (r_fire && !last_beat);
  assign mem.we    = 1'b0;
  assign mem.idx   = ar_fire ? word_index(i_araddr) : word_index(next_addr);
  assign mem.wdata = '0;
  assign mem.wstrb = '0;

  // --------------------
  // AXI outputs
  // --------------------
  assign o_arready = (state_q == RD_IDLE);
  assign o_rvalid  = (state_q == RD_BURST);
  assign o_rid     = id_q;
  assign o_rlast   = o_rvalid && last_beat;
  assign o_rresp   = beat_err ? RESP_SLVERR : RESP_OKAY;
  assign o_rdata   = beat_err ? '0 : mem.rdata;

endmodule

// File: source/mem_port_if.sv
// One SRAM access port between a channel controller and the memory array
`timescale 1ns/100ps

interface mem_port_if
  import mem_pkg::*;
();

  logic  en;
  logic  we;
  widx_t idx;
  word_t wdata;
  strb_t wstrb;
  // Registered read data, valid the cycle after en without we
  word_t rdata;

  modport ctrl (
    output en, we, idx, wdata, wstrb,
    input  rdata
  );

  modport mem (
    input  en, we, idx, wdata, wstrb,
    output rdata
  );

endinterface

// File: source/mem_pkg.sv
// Memory-side types and the address range rule for the AXI SRAM array
`include "axi_sram_config.svh"

package mem_pkg;

  localparam int unsigned WORD_BYTES = `AXI_DATA_WIDTH / 8;
  localparam int unsigned OFFS_BITS  = $clog2(WORD_BYTES);
  localparam int unsigned IDX_WIDTH  = $clog2(`SRAM_DEPTH);

  typedef logic [`AXI_DATA_WIDTH-1:0] word_t;
  typedef logic [WORD_BYTES-1:0]      strb_t;
  typedef logic [IDX_WIDTH-1:0]       widx_t;
  typedef logic [`AXI_ADDR_WIDTH-1:0] byte_addr_t;

  // True when the word holding this byte address exists in the array
  function automatic logic in_range(input byte_addr_t addr);
    return addr[`AXI_ADDR_WIDTH-1:OFFS_BITS] < `SRAM_DEPTH;
  endfunction

  function automatic widx_t word_index(input byte_addr_t addr);
    return addr[OFFS_BITS +: IDX_WIDTH];
  endfunction

endpackage

// File: source/axi_pkg.sv
// AXI4 protocol types shared by the channel controllers, the top level and the checker
`include "axi_sram_config.svh"

package axi_pkg;

  // Burst encoding as on AxBURST
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // Beats minus one
  typedef logic [7:0] len_t;

  typedef logic [`AXI_ID_WIDTH-1:0] id_t;

  // Only FIXED and INCR are served, anything else errors every beat
  function automatic logic burst_supported(input burst_e burst);
    return (burst == BURST_FIXED) || (burst == BURST_INCR);
  endfunction

endpackage

// File: source/axi_sram_config.svh
// Bus and memory size macros for the AXI SRAM, included by packages, RTL and testbench
`ifndef AXI_SRAM_CONFIG_SVH
`define AXI_SRAM_CONFIG_SVH

// --------------------
// AXI bus
// --------------------
`define AXI_DATA_WIDTH 64
`define AXI_ADDR_WIDTH 32
`define AXI_ID_WIDTH   4

// --------------------
// Memory array
// --------------------
// Depth in full-width words
`define SRAM_DEPTH 1024

`endif
